// ==== Makefile ====
# Verilator build for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= axis_conv_engine_tb
SEED      ?= 60580
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -GSEED=$(SEED) $(VFLAGS) -f $(FILELIST)

# The simulator exits with a failing status on $fatal or an assertion error
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/axis_conv_engine_chk.sv ====
`timescale 1ns/10ps

module axis_conv_engine_chk
  import conv_pkg::*;
(
  input logic                                    aclk,
  input logic                                    reset,
  input logic                                    m_axis_tvalid,
  input logic                                    m_axis_tready,
  input logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0] m_axis_tdata,
  input logic                                    m_axis_tlast,
  input logic [TUSER_WIDTH_CONV_OUT-1:0]         m_axis_tuser
);

  // Synchronous reset clears valid on the edge that samples it
  a_valid_low_in_reset : assert property (@(posedge aclk) reset |=> !m_axis_tvalid)
    else $error("m_axis_tvalid high while reset is applied");

  // A stalled output beat keeps its valid and its payload
  a_output_holds : assert property (@(posedge aclk) disable iff (reset)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser)
       && $stable(m_axis_tlast)))
    else $error("m_axis output changed while stalled");

  // Every output beat closes a run
  a_last_on_every_beat : assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid |-> m_axis_tlast)
    else $error("m_axis_tlast low on a valid output beat");

endmodule

bind axis_conv_engine axis_conv_engine_chk chk0 (
  .aclk          (aclk),
  .reset         (reset),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tuser  (m_axis_tuser)
);

// ==== dv/axis_conv_engine_tb.sv ====
`timescale 1ns/10ps

module axis_conv_engine_tb
  import conv_pkg::*;
#(
  parameter int unsigned SEED = 32'heca4
);

  localparam int NUM_RUNS    = 40;
  localparam int FIXED_RUNS  = 6;
  localparam int LONG_RUN    = 520;
  localparam int MAX_BEATS   = 1024;
  localparam int OUT_LATENCY = 4;
  localparam int SUM_BITS    = MEMBERS*UNITS*WORD_WIDTH_ACC;

  logic                              aclk;
  logic                              reset;
  logic                              s_axis_tvalid;
  logic                              s_axis_tready;
  logic                              s_axis_tlast;
  logic [TUSER_WIDTH_CONV_IN-1:0]    s_axis_tuser;
  logic [UNITS*WORD_WIDTH-1:0]       s_axis_tdata_pixels;
  logic [MEMBERS*WORD_WIDTH-1:0]     s_axis_tdata_weights;
  logic                              m_axis_tvalid;
  logic                              m_axis_tready;
  logic [SUM_BITS-1:0]               m_axis_tdata;
  logic                              m_axis_tlast;
  logic [TUSER_WIDTH_CONV_OUT-1:0]   m_axis_tuser;

  // Run table: beats are stored flat, each run points at its first beat
  logic [UNITS*WORD_WIDTH-1:0]       beat_pixels  [MAX_BEATS];
  logic [MEMBERS*WORD_WIDTH-1:0]     beat_weights [MAX_BEATS];
  int                                run_start    [NUM_RUNS];
  int                                run_len      [NUM_RUNS];
  logic                              run_user     [NUM_RUNS];
  logic [SUM_BITS-1:0]               run_expect   [NUM_RUNS];
  int                                accept_cycle [NUM_RUNS];

  int total_beats    = 0;
  int timeout_cycles = 0;
  int cycle_count    = 0;
  int outputs_seen   = 0;
  bit hold_ready     = 1'b1;

  axis_conv_engine dut0 (
    .aclk                 (aclk),
    .reset                (reset),
    .s_axis_tvalid        (s_axis_tvalid),
    .s_axis_tready        (s_axis_tready),
    .s_axis_tlast         (s_axis_tlast),
    .s_axis_tuser         (s_axis_tuser),
    .s_axis_tdata_pixels  (s_axis_tdata_pixels),
    .s_axis_tdata_weights (s_axis_tdata_weights),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_tready        (m_axis_tready),
    .m_axis_tdata         (m_axis_tdata),
    .m_axis_tlast         (m_axis_tlast),
    .m_axis_tuser         (m_axis_tuser)
  );

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  always @(posedge aclk) cycle_count <= cycle_count + 1;

  task automatic abort_run(string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Wrapped signed sum of pixel times weight over a run, per member and lane
  function automatic logic [SUM_BITS-1:0] reference_sums(int first_beat, int beats);
    logic [SUM_BITS-1:0]              sums;
    logic signed [WORD_WIDTH-1:0]     px;
    logic signed [WORD_WIDTH-1:0]     wt;
    logic signed [WORD_WIDTH_ACC-1:0] acc;
    sums = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        acc = '0;
        for (int i = 0; i < beats; i++) begin
          px  = beat_pixels[first_beat+i][u*WORD_WIDTH +: WORD_WIDTH];
          wt  = beat_weights[first_beat+i][m*WORD_WIDTH +: WORD_WIDTH];
          acc = acc + px * wt;
        end
        sums[(m*UNITS+u)*WORD_WIDTH_ACC +: WORD_WIDTH_ACC] = acc;
      end
    end
    return sums;
  endfunction

  // Runs 0 and 1 hit the operand extremes, the long run wraps the sums
  task automatic build_table();
    int b;
    b = 0;
    for (int r = 0; r < NUM_RUNS; r++) begin
      run_start[r] = b;
      case (r)
        2:          run_len[r] = 3;
        5:          run_len[r] = 4;
        FIXED_RUNS: run_len[r] = LONG_RUN;
        default:    run_len[r] = (r < FIXED_RUNS) ? 1 : 1 + int'($urandom_range(7));
      endcase
      run_user[r] = 1'($urandom_range(1));
      for (int i = 0; i < run_len[r]; i++) begin
        if (r == 0) begin
          beat_pixels[b]  = {8'h00, 8'hff, 8'h7f, 8'h80};
          beat_weights[b] = {8'hff, 8'h01, 8'h7f, 8'h80};
        end else if (r == 1) begin
          beat_pixels[b]  = {UNITS{8'h7f}};
          beat_weights[b] = {MEMBERS{8'h80}};
        end else if (r == FIXED_RUNS) begin
          beat_pixels[b]  = {UNITS{8'h80}};
          beat_weights[b] = {MEMBERS{8'h80}};
        end else begin
          for (int k = 0; k < UNITS; k++) begin
            beat_pixels[b][k*WORD_WIDTH +: WORD_WIDTH] = WORD_WIDTH'($urandom);
          end
          for (int k = 0; k < MEMBERS; k++) begin
            beat_weights[b][k*WORD_WIDTH +: WORD_WIDTH] = WORD_WIDTH'($urandom);
          end
        end
        b++;
      end
      run_expect[r] = reference_sums(run_start[r], run_len[r]);
    end
    total_beats = b;
  endtask

  task automatic idle_inputs();
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  // Called on a falling edge and returns on the falling edge after the last beat is taken
  task automatic send_run(int r, bit gaps);
    int b;
    bit taken;
    for (int i = 0; i < run_len[r]; i++) begin
      b = run_start[r] + i;
      if (gaps && $urandom_range(3) == 0) begin
        idle_inputs();
        repeat (1 + $urandom_range(2)) @(negedge aclk);
      end
      s_axis_tvalid        = 1'b1;
      s_axis_tlast         = (i == run_len[r] - 1);
      s_axis_tuser         = s_axis_tlast ? run_user[r] : 1'($urandom_range(1));
      s_axis_tdata_pixels  = beat_pixels[b];
      s_axis_tdata_weights = beat_weights[b];
      taken = 1'b0;
      while (!taken) begin
        taken = s_axis_tready;
        if (taken && s_axis_tlast) begin
          accept_cycle[r] = cycle_count;
        end
        @(negedge aclk);
      end
    end
  endtask

  task automatic check_output();
    logic [WORD_WIDTH_ACC-1:0] got;
    logic [WORD_WIDTH_ACC-1:0] want;
    int r;
    int lag;
    r = outputs_seen;
    assert (r < NUM_RUNS)
      else abort_run("An output beat arrived after every run had been received");
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        got  = m_axis_tdata[(m*UNITS+u)*WORD_WIDTH_ACC +: WORD_WIDTH_ACC];
        want = run_expect[r][(m*UNITS+u)*WORD_WIDTH_ACC +: WORD_WIDTH_ACC];
        assert (got == want)
          else abort_run($sformatf(
                   "Mismatch m_axis_tdata member %0d lane %0d run %0d: got %h, expected %h",
                   m, u, r, got, want));
      end
    end
    assert (m_axis_tuser[I_IS_LRELU] == run_user[r])
      else abort_run($sformatf("Mismatch m_axis_tuser run %0d: got %h, expected %h",
                               r, m_axis_tuser, run_user[r]));
    assert (m_axis_tlast)
      else abort_run($sformatf("Mismatch m_axis_tlast run %0d: got %h, expected %h",
                               r, m_axis_tlast, 1'b1));
    // Only the first runs go out with ready held high and no stalls
    if (r < FIXED_RUNS) begin
      lag = cycle_count - accept_cycle[r];
      assert (lag == OUT_LATENCY)
        else abort_run($sformatf("Run %0d came out %0d cycles after its last beat instead of %0d",
                                 r, lag, OUT_LATENCY));
    end
    outputs_seen++;
  endtask

  always @(negedge aclk) begin
    if (!reset) begin
      m_axis_tready = hold_ready ? 1'b1 : ($urandom_range(9) < 6);
      if (m_axis_tvalid && m_axis_tready) begin
        check_output();
      end
    end
  end

  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge aclk);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_cycles));
  end

  initial begin
    void'($urandom(SEED));
    reset                = 1'b1;
    s_axis_tvalid        = 1'b0;
    s_axis_tlast         = 1'b0;
    s_axis_tuser         = '0;
    s_axis_tdata_pixels  = '0;
    s_axis_tdata_weights = '0;
    m_axis_tready        = 1'b0;
    build_table();
    timeout_cycles = 8 * total_beats + 40 * NUM_RUNS + 200;
    repeat (3) @(negedge aclk);
    reset = 1'b0;
    assert (!m_axis_tvalid)
      else abort_run($sformatf("Mismatch m_axis_tvalid after reset: got %h, expected %h",
                               m_axis_tvalid, 1'b0));
    assert (s_axis_tready)
      else abort_run($sformatf("Mismatch s_axis_tready after reset: got %h, expected %h",
                               s_axis_tready, 1'b1));
    for (int r = 0; r < NUM_RUNS; r++) begin
      if (r == FIXED_RUNS) begin
        idle_inputs();
        while (outputs_seen < FIXED_RUNS) @(negedge aclk);
        hold_ready = 1'b0;
      end
      send_run(r, r >= FIXED_RUNS);
    end
    idle_inputs();
    while (outputs_seen < NUM_RUNS) @(negedge aclk);
    repeat (10) @(negedge aclk);
    if (outputs_seen == NUM_RUNS && !m_axis_tvalid) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("Output stream did not settle after the last run");
    end
  end

endmodule

// ==== list.f ====
src/conv_pkg.sv
src/conv_multiplier.sv
src/conv_accumulator.sv
src/conv_engine.sv
src/slice_conv_active.sv
src/axis_conv_engine.sv
dv/axis_conv_engine_chk.sv
dv/axis_conv_engine_tb.sv

// ==== src/axis_conv_engine.sv ====
`timescale 1ns/10ps

module axis_conv_engine
  import conv_pkg::*;
(
  input  logic                                      aclk,
  input  logic                                      reset,
  input  logic                                      s_axis_tvalid,
  output logic                                      s_axis_tready,
  input  logic                                      s_axis_tlast,
  input  logic [TUSER_WIDTH_CONV_IN-1:0]            s_axis_tuser,
  input  logic [UNITS*WORD_WIDTH-1:0]               s_axis_tdata_pixels,
  input  logic [MEMBERS*WORD_WIDTH-1:0]             s_axis_tdata_weights,
  output logic                                      m_axis_tvalid,
  input  logic                                      m_axis_tready,
  output logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]   m_axis_tdata,
  output logic                                      m_axis_tlast,
  output logic [TUSER_WIDTH_CONV_OUT-1:0]           m_axis_tuser
);

  logic                                     engine_valid;
  logic                                     engine_last;
  logic [TUSER_WIDTH_CONV_OUT-1:0]          engine_user;
  logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]  engine_data;

  // The slice ready doubles as the engine clock enable and the input ready
  conv_engine engine (
    .aclk           (aclk),
    .clken          (s_axis_tready),
    .reset          (reset),
    .s_valid        (s_axis_tvalid),
    .s_last         (s_axis_tlast),
    .s_user         (s_axis_tuser),
    .s_data_pixels  (s_axis_tdata_pixels),
    .s_data_weights (s_axis_tdata_weights),
    .m_valid        (engine_valid),
    .m_last         (engine_last),
    .m_user         (engine_user),
    .m_data         (engine_data)
  );

  slice_conv_active slice (
    .aclk          (aclk),
    .reset         (reset),
    .s_axis_tvalid (engine_valid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (engine_data),
    .s_axis_tuser  (engine_user),
    .s_axis_tlast  (engine_last),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

// ==== src/conv_accumulator.sv ====
`timescale 1ns/10ps

module conv_accumulator
  import conv_pkg::*;
(
  input  logic                               aclk,
  input  logic                               clken,
  input  logic                               reset,
  input  logic                               valid,
  input  logic                               last,
  input  logic signed [2*WORD_WIDTH-1:0]     product,
  output logic                               sum_valid,
  output logic signed [WORD_WIDTH_ACC-1:0]   sum
);

  logic                             first;
  logic signed [WORD_WIDTH_ACC-1:0] product_ext;

  assign product_ext = {{(WORD_WIDTH_ACC - 2*WORD_WIDTH){product[2*WORD_WIDTH-1]}}, product};

  // The first valid product after a last beat starts a new run
  always_ff @(posedge aclk) begin
    if (reset) begin
      first     <= 1'b1;
      sum_valid <= 1'b0;
    end else if (clken) begin
      sum_valid <= valid && last;
      if (valid) begin
        first <= last;
      end
    end
  end

  // Invalid beats leave the running sum untouched
  always_ff @(posedge aclk) begin
    if (clken && valid) begin
      if (first) begin
        sum <= product_ext;
      end else begin
        sum <= sum + product_ext;
      end
    end
  end

endmodule

// ==== src/conv_engine.sv ====
`timescale 1ns/10ps

module conv_engine
  import conv_pkg::*;
(
  input  logic                                      aclk,
  input  logic                                      clken,
  input  logic                                      reset,
  input  logic                                      s_valid,
  input  logic                                      s_last,
  input  logic [TUSER_WIDTH_CONV_IN-1:0]            s_user,
  input  logic [UNITS*WORD_WIDTH-1:0]               s_data_pixels,
  input  logic [MEMBERS*WORD_WIDTH-1:0]             s_data_weights,
  output logic                                      m_valid,
  output logic                                      m_last,
  output logic [TUSER_WIDTH_CONV_OUT-1:0]           m_user,
  output logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]   m_data
);

  logic [LATENCY_MULTIPLIER-1:0]                        valid_pipe;
  logic [LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-1:0]    last_pipe;
  logic [LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-1:0]    user_pipe;
  logic [MEMBERS*UNITS-1:0]                             sum_valid;
  logic                                                 acc_valid;
  logic                                                 acc_last;

  // Valid travels beside the products and stops at the accumulators
  always_ff @(posedge aclk) begin
    if (reset) begin
      valid_pipe <= '0;
    end else if (clken) begin
      valid_pipe <= {valid_pipe[LATENCY_MULTIPLIER-2:0], s_valid};
    end
  end

  // Last and user ride on through the accumulator stage to line up with the sums
  always_ff @(posedge aclk) begin
    if (reset) begin
      last_pipe <= '0;
    end else if (clken) begin
      last_pipe <= {last_pipe[LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-2:0], s_last};
    end
  end

  always_ff @(posedge aclk) begin
    if (clken) begin
      user_pipe <= {user_pipe[LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-2:0], s_user[I_IS_LRELU]};
    end
  end

  assign acc_valid = valid_pipe[LATENCY_MULTIPLIER-1];
  assign acc_last  = last_pipe[LATENCY_MULTIPLIER-1];

  // Every pixel lane meets every weight
  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      logic signed [2*WORD_WIDTH-1:0] product;

      conv_multiplier mul (
        .aclk  (aclk),
        .clken (clken),
        .a     (s_data_pixels[u*WORD_WIDTH +: WORD_WIDTH]),
        .b     (s_data_weights[m*WORD_WIDTH +: WORD_WIDTH]),
        .p     (product)
      );

      conv_accumulator acc (
        .aclk      (aclk),
        .clken     (clken),
        .reset     (reset),
        .valid     (acc_valid),
        .last      (acc_last),
        .product   (product),
        .sum_valid (sum_valid[m*UNITS+u]),
        .sum       (m_data[(m*UNITS+u)*WORD_WIDTH_ACC +: WORD_WIDTH_ACC])
      );
    end
  end

  // All accumulators strobe together
  assign m_valid = &sum_valid;
  assign m_last  = last_pipe[LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-1];

  always_comb begin
    m_user             = '0;
    m_user[I_IS_LRELU] = user_pipe[LATENCY_MULTIPLIER+LATENCY_ACCUMULATOR-1];
  end

endmodule

// ==== src/conv_multiplier.sv ====
`timescale 1ns/10ps

module conv_multiplier
  import conv_pkg::*;
(
  input  logic                           aclk,
  input  logic                           clken,
  input  logic signed [WORD_WIDTH-1:0]   a,
  input  logic signed [WORD_WIDTH-1:0]   b,
  output logic signed [2*WORD_WIDTH-1:0] p
);

  logic signed [WORD_WIDTH-1:0]   a_q;
  logic signed [WORD_WIDTH-1:0]   b_q;
  logic signed [2*WORD_WIDTH-1:0] p_q [LATENCY_MULTIPLIER-1];

  // Operand registers form the first stage, product registers the rest
  always_ff @(posedge aclk) begin
    if (clken) begin
      a_q <= a;
      b_q <= b;
    end
  end

  always_ff @(posedge aclk) begin
    if (clken) begin
      p_q[0] <= a_q * b_q;
    end
  end

  // Extra output stages only exist when the latency is raised above two
  for (genvar i = 1; i < LATENCY_MULTIPLIER - 1; i++) begin : g_stage
    always_ff @(posedge aclk) begin
      if (clken) begin
        p_q[i] <= p_q[i-1];
      end
    end
  end

  assign p = p_q[LATENCY_MULTIPLIER-2];

endmodule

// ==== src/conv_pkg.sv ====
package conv_pkg;

  // Pixel lanes and weights carried by one input beat
  localparam int UNITS   = 4;
  localparam int MEMBERS = 4;

  // Signed operand width and accumulated sum width, sums wrap modulo 2**24
  localparam int WORD_WIDTH     = 8;
  localparam int WORD_WIDTH_ACC = 24;

  // Register stages inside the multiplier and the accumulator
  localparam int LATENCY_MULTIPLIER  = 2;
  localparam int LATENCY_ACCUMULATOR = 1;

  // User field on the input and output streams
  localparam int TUSER_WIDTH_CONV_IN  = 1;
  localparam int TUSER_WIDTH_CONV_OUT = 1;
  localparam int I_IS_LRELU           = 0;

  // Occupancy of the output slice
  typedef enum logic [1:0] {
    slice_empty,
    slice_one,
    slice_two
  } slice_state_e;

endpackage

// ==== src/slice_conv_active.sv ====
`timescale 1ns/10ps

module slice_conv_active
  import conv_pkg::*;
(
  input  logic                                      aclk,
  input  logic                                      reset,
  input  logic                                      s_axis_tvalid,
  output logic                                      s_axis_tready,
  input  logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]   s_axis_tdata,
  input  logic [TUSER_WIDTH_CONV_OUT-1:0]           s_axis_tuser,
  input  logic                                      s_axis_tlast,
  output logic                                      m_axis_tvalid,
  input  logic                                      m_axis_tready,
  output logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]   m_axis_tdata,
  output logic [TUSER_WIDTH_CONV_OUT-1:0]           m_axis_tuser,
  output logic                                      m_axis_tlast
);

  slice_state_e                             state;
  slice_state_e                             state_next;
  logic                                     accept;
  logic                                     pop;
  logic                                     load_out_in;
  logic                                     load_out_skid;
  logic                                     load_skid;
  logic [MEMBERS*UNITS*WORD_WIDTH_ACC-1:0]  skid_data;
  logic [TUSER_WIDTH_CONV_OUT-1:0]          skid_user;
  logic                                     skid_last;

  assign accept = s_axis_tvalid && s_axis_tready;
  assign pop    = m_axis_tvalid && m_axis_tready;

  always_comb begin
    state_next = state;
    case (state)
      slice_empty: begin
        if (accept) begin
          state_next = slice_one;
        end
      end
      slice_one: begin
        if (accept && !pop) begin
          state_next = slice_two;
        end else if (!accept && pop) begin
          state_next = slice_empty;
        end
      end
      slice_two: begin
        if (pop) begin
          state_next = slice_one;
        end
      end
      default: state_next = slice_empty;
    endcase
  end

  // Ready and valid come straight from flops, decoded from the next state
  always_ff @(posedge aclk) begin
    if (reset) begin
      state         <= slice_empty;
      s_axis_tready <= 1'b1;
      m_axis_tvalid <= 1'b0;
    end else begin
      state         <= state_next;
      s_axis_tready <= (state_next != slice_two);
      m_axis_tvalid <= (state_next != slice_empty);
    end
  end

  assign load_out_in   = accept && (state == slice_empty || (state == slice_one && pop));
  assign load_out_skid = pop && (state == slice_two);
  assign load_skid     = accept && !pop && (state == slice_one);

  always_ff @(posedge aclk) begin
    if (load_out_in) begin
      m_axis_tdata <= s_axis_tdata;
      m_axis_tuser <= s_axis_tuser;
      m_axis_tlast <= s_axis_tlast;
    end else if (load_out_skid) begin
      m_axis_tdata <= skid_data;
      m_axis_tuser <= skid_user;
      m_axis_tlast <= skid_last;
    end
  end

  // Skid entry catches the beat that lands while the output is stuck
  always_ff @(posedge aclk) begin
    if (load_skid) begin
      skid_data <= s_axis_tdata;
      skid_user <= s_axis_tuser;
      skid_last <= s_axis_tlast;
    end
  end

endmodule
